/* include/emesh_macros.svh */
`ifndef EMESH_MACROS_SVH
`define EMESH_MACROS_SVH

// ##############################
// buffer sizing
// ##############################

// number of packet slots in the buffer
`define EMESH_DEPTH 8

// pointer width for EMESH_DEPTH entries
`define EMESH_AW 3

// ##############################
// link format
// ##############################

`define EMESH_PW 104               // full mesh packet width

// upstream wait rises at this occupancy
// leaves two slots for packets already in flight
`define EMESH_PROG_FULL 6

`endif

/* verilog/emesh_pkg.sv */
`default_nettype none

`include "emesh_macros.svh"

package emesh_pkg;

   // ##############################
   // packet field encodings
   // ##############################

   // transaction direction
   typedef enum logic [0:0]
   {
      CMD_READ  = 1'b0,
      CMD_WRITE = 1'b1
   } emesh_cmd_e;

   // access size of the data field
   typedef enum logic [1:0]
   {
      SIZE_BYTE   = 2'd0,            // 8 bit
      SIZE_HALF   = 2'd1,            // 16 bit
      SIZE_WORD   = 2'd2,            // 32 bit
      SIZE_DOUBLE = 2'd3             // 64 bit, two beats
   } emesh_size_e;

   // mesh packet as stored in the buffer, msb first
   typedef struct packed
   {
      emesh_cmd_e  cmd;              // read or write
      emesh_size_e size;
      logic [4:0]  ctrlmode;         // routing / ordering hints
      logic [31:0] dstaddr;
      logic [31:0] srcaddr;          // return address for reads
      logic [31:0] data;
   } emesh_packet_t;

   // ##############################
   // buffer status
   // ##############################

   typedef struct packed
   {
      logic                full;
      logic                prog_full;  // drives upstream wait
      logic                empty;
      logic [`EMESH_AW:0]  count;      // valid entries, 0..DEPTH
   } fifo_status_t;

endpackage

`default_nettype wire

/* verilog/memory_dp.sv */
`default_nettype none

// simple dual port ram, one clock
// read data comes out of a register, one edge after rd_en
module memory_dp
  #(
   parameter int DW = 104,           // word width
   parameter int AW = 3              // address width
   )
   (
   input  wire           clk,
   // write port
   input  wire           wr_en,
   input  wire [AW-1:0]  wr_addr,
   input  wire [DW-1:0]  wr_din,
   // read port
   input  wire           rd_en,
   input  wire [AW-1:0]  rd_addr,
   output logic [DW-1:0] rd_dout     // valid after the rd_en edge
   );

   localparam int DEPTH = 1 << AW;

   // ##############################
   // storage
   // ##############################

   logic [DW-1:0] mem [0:DEPTH-1];

   // whole word written, no byte enables
   always_ff @(posedge clk)
      if (wr_en)
         mem[wr_addr] <= wr_din;

   // ##############################
   // read register
   // ##############################

   // loads only on rd_en
   // so the last word read stays on rd_dout
   always_ff @(posedge clk)
      if (rd_en)
         rd_dout <= mem[rd_addr];    // old data if same addr written this edge

endmodule

`default_nettype wire

/* verilog/fifo_sync.sv */
`default_nettype none

`include "emesh_macros.svh"

// single clock fifo on top of memory_dp
// dout follows rd_en by one edge
module fifo_sync
  #(
   parameter int DW        = `EMESH_PW,
   parameter int DEPTH     = `EMESH_DEPTH,
   parameter int PROG_FULL = DEPTH/2
   )
   (
   input  wire                     clk,
   input  wire                     nreset,
   // write side
   input  wire [DW-1:0]            din,
   input  wire                     wr_en,     // caller keeps this low when full
   // read side
   input  wire                     rd_en,     // caller keeps this low when empty
   output logic [DW-1:0]           dout,
   // flags
   output emesh_pkg::fifo_status_t status
   );

   localparam int AW = $clog2(DEPTH);
   localparam int CW = `EMESH_AW + 1;          // width of status count field

   // ##############################
   // pointers and occupancy
   // ##############################

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;                       // 0..DEPTH, one extra bit

   // pointers wrap at depth by overflow
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         // both at once leaves count alone
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end

   // ##############################
   // status flags
   // ##############################

   // all compares on registered count
   always_comb
   begin
      status.empty     = (count == '0);
      status.full      = (count == (AW+1)'(DEPTH));
      status.prog_full = (count >= (AW+1)'(PROG_FULL));
      status.count     = CW'(count);
   end

   // storage, read data registered inside
   memory_dp
     #(.DW (DW),
       .AW (AW))
   u_mem
     (.clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_ptr),
      .wr_din  (din),
      .rd_en   (rd_en),
      .rd_addr (rd_ptr),
      .rd_dout (dout));

endmodule

`default_nettype wire

/* verilog/fifo_egress.sv */
`default_nettype none

// output stage of the transaction buffer
// pops the fifo and presents one packet to downstream
// packet stays put while downstream holds wait_in
module fifo_egress
   (
   input  wire                           clk,
   input  wire                           nreset,
   // fifo side
   input  wire emesh_pkg::fifo_status_t  status,
   input  wire emesh_pkg::emesh_packet_t fifo_dout,  // registered mem output
   output logic                          rd_en,      // pop request
   // downstream side
   input  wire                           wait_in,
   output logic                          access_out,
   output emesh_pkg::emesh_packet_t      packet_out
   );

   // ##############################
   // output slot
   // ##############################

   // one packet can sit at the memory read register
   // out_valid says whether it still needs to go out
   logic out_valid;
   logic pkt_taken;                  // downstream accepts this cycle
   logic slot_free;                  // room for the next pop
   logic fifo_has_data;

   assign fifo_has_data = ~status.empty;

   // delivered on an edge with access high and no wait
   assign pkt_taken = out_valid & ~wait_in;

   // slot empty or being emptied right now
   assign slot_free = ~out_valid | pkt_taken;

   // ##############################
   // pop control
   // ##############################

   // combinational pop
   // next word lands in rd_dout on the same edge the old one leaves
   // so back to back packets go out every cycle
   assign rd_en = fifo_has_data & slot_free;

   // valid follows rd_en by one edge, like the memory data
   // frozen while downstream waits on a full slot
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         out_valid <= 1'b0;
      else if (slot_free)
         out_valid <= rd_en;     // new word or slot goes empty

   // ##############################
   // outputs
   // ##############################

   assign access_out = out_valid;

   // memory only reloads on rd_en, so this holds under wait
   assign packet_out = fifo_dout;

endmodule

`default_nettype wire

/* verilog/emesh_fifo.sv */
`default_nettype none

`include "emesh_macros.svh"

// transaction buffer for the mesh packet link
// strobe in, strobe out, wait levels both ways
module emesh_fifo
   (
   input  wire                           clk,
   input  wire                           nreset,
   // upstream
   input  wire                           access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   output logic                          wait_out,    // stop sending
   // downstream
   output wire                           access_out,
   output wire emesh_pkg::emesh_packet_t packet_out,
   input  wire                           wait_in,
   // buffer state
   output emesh_pkg::fifo_status_t       status
   );

   // ##############################
   // packet <-> fifo word
   // ##############################

   logic [`EMESH_PW-1:0]     fifo_din;
   logic [`EMESH_PW-1:0]     fifo_dout;
   emesh_pkg::emesh_packet_t fifo_pkt;
   logic                     fifo_rd_en;   // from egress

   assign fifo_din = `EMESH_PW'(packet_in);
   assign fifo_pkt = emesh_pkg::emesh_packet_t'(fifo_dout);

   // upstream must honour this, writes when full are not blocked
   assign wait_out = status.prog_full;

   // ##############################
   // buffer and output stage
   // ##############################

   fifo_sync
     #(.DW        (`EMESH_PW),
       .DEPTH     (`EMESH_DEPTH),
       .PROG_FULL (`EMESH_PROG_FULL))
   u_fifo
     (.clk    (clk),
      .nreset (nreset),
      .din    (fifo_din),
      .wr_en  (access_in),     // every strobe stores a packet
      .rd_en  (fifo_rd_en),
      .dout   (fifo_dout),
      .status (status));

   fifo_egress u_egress
     (.clk        (clk),
      .nreset     (nreset),
      .status     (status),
      .fifo_dout  (fifo_pkt),
      .rd_en      (fifo_rd_en),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out));

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

// free running testbench clock
module tb_clock
  #(
   parameter int PERIOD = 40         // full period in time units
   )
   (
   output logic clk
   );

   initial
      clk = 1'b0;

   always #(PERIOD/2) clk = ~clk;    // 50% duty

endmodule

`default_nettype wire

/* tests/tb_emesh_fifo.sv */
`default_nettype none

`include "emesh_macros.svh"

// testbench for the mesh transaction buffer
// stimulus lines come from a file, one cycle each
module tb_emesh_fifo;

   localparam int DRAIN_LIMIT = 64;  // cycles allowed for the final drain

   // ##############################
   // dut signals
   // ##############################

   logic                     clk;
   logic                     nreset;
   logic                     access_in;
   emesh_pkg::emesh_packet_t packet_in;
   logic                     wait_out;
   logic                     access_out;
   emesh_pkg::emesh_packet_t packet_out;
   logic                     wait_in;
   emesh_pkg::fifo_status_t  status;

   // reference model state
   emesh_pkg::emesh_packet_t model_q[$];   // everything inside the buffer, oldest first
   int                       m_fcount;     // entries still in the fifo
   logic                     m_slot;       // packet waiting at the output
   logic                     held_valid;   // output was stalled last cycle
   emesh_pkg::emesh_packet_t held_pkt;
   integer                   seed;

   tb_clock #(.PERIOD (40)) u_clock (.clk (clk));

   emesh_fifo u_emesh_fifo
     (.clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .status     (status));

   // ##############################
   // checks
   // ##############################

   task automatic abort_run(input string why);
      if (why != "")
         $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_packet(input string name, input emesh_pkg::emesh_packet_t exp,
                               input emesh_pkg::emesh_packet_t act);
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
         abort_run("");
      end
   endtask

   task automatic check_status(input string name, input emesh_pkg::fifo_status_t exp,
                               input emesh_pkg::fifo_status_t act);
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
         abort_run("");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
         abort_run("");
      end
   endtask

   // flags as compares on the occupancy
   function automatic emesh_pkg::fifo_status_t expected_status(input int fc);
      emesh_pkg::fifo_status_t s;
      s.full      = (fc == `EMESH_DEPTH);
      s.prog_full = (fc >= `EMESH_PROG_FULL);
      s.empty     = (fc == 0);
      s.count     = (`EMESH_AW+1)'(fc);
      return s;
   endfunction

   task automatic make_random_packet(output emesh_pkg::emesh_packet_t p);
      logic [31:0] r;
      r          = $random(seed);
      p.cmd      = emesh_pkg::emesh_cmd_e'(r[0]);
      p.size     = emesh_pkg::emesh_size_e'(r[2:1]);
      p.ctrlmode = r[7:3];
      p.dstaddr  = $random(seed);
      p.srcaddr  = $random(seed);
      p.data     = $random(seed);
   endtask

   // ##############################
   // one cycle of stimulus
   // ##############################

   // mid cycle compare, then step the model over the coming edge
   task automatic check_cycle(input logic acc, input emesh_pkg::emesh_packet_t pkt,
                              input logic wt);
      logic taken;
      logic rd;
      check_status("status", expected_status(m_fcount), status);
      check_bit("wait_out", (m_fcount >= `EMESH_PROG_FULL), wait_out);
      check_bit("access_out", m_slot, access_out);
      if (held_valid)
         check_packet("packet_out (held)", held_pkt, packet_out);
      if (m_slot)
         check_packet("packet_out", model_q[0], packet_out);
      held_valid = m_slot && wt;                      // stalled over the coming edge
      if (held_valid)
         held_pkt = model_q[0];
      taken = m_slot && !wt;                          // delivered on this edge
      if (taken)
         void'(model_q.pop_front());
      rd = (m_fcount != 0) && (!m_slot || taken);    // egress pop
      if (acc && (m_fcount == `EMESH_DEPTH) && !rd)
         abort_run("stimulus writes into a full buffer");
      if (acc)
         model_q.push_back(pkt);
      m_fcount = m_fcount + int'(acc) - int'(rd);
      if (!m_slot || taken)
         m_slot = rd;                                 // slot reloads or empties
   endtask

   task automatic drive_cycle(input logic acc, input emesh_pkg::emesh_packet_t pkt,
                              input logic wt);
      @(posedge clk);
      access_in <= acc;
      packet_in <= pkt;
      wait_in   <= wt;
      @(negedge clk);                                 // outputs settled here
      check_cycle(acc, pkt, wt);
   endtask

   // ##############################
   // main sequence
   // ##############################

   initial
   begin
      int                       fd;
      int                       n;
      int                       cycles;
      bit                       done;
      string                    line;
      logic [31:0]              f_acc, f_cmd, f_size, f_ctrl;
      logic [31:0]              f_dst, f_src, f_data, f_wait;
      logic [31:0]              r;
      logic                     acc;
      logic                     wt;
      emesh_pkg::emesh_packet_t pkt;
      nreset     = 1'b0;
      access_in  = 1'b0;
      packet_in  = '0;
      wait_in    = 1'b0;
      seed       = 46;
      m_fcount   = 0;
      m_slot     = 1'b0;
      held_valid = 1'b0;
      held_pkt   = '0;
      repeat (4) @(posedge clk);
      nreset <= 1'b1;
      @(negedge clk);
      check_bit("access_out", 1'b0, access_out);      // idle after reset
      check_bit("wait_out", 1'b0, wait_out);
      check_status("status", expected_status(0), status);

      fd = $fopen("tests/emesh_fifo_stimulus.txt", "r");
      if (fd == 0)
         abort_run("could not open tests/emesh_fifo_stimulus.txt");
      done = 1'b0;
      while (!done)
      begin
         n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                     f_acc, f_cmd, f_size, f_ctrl, f_dst, f_src, f_data, f_wait);
         if (n < 0)
            done = 1'b1;                              // end of file
         else if (n == 0)
         begin
            if ($fgets(line, fd) == 0)                // comment line, skip it
               done = 1'b1;
         end
         else if (n != 8)
            abort_run("malformed line in the stimulus file");
         else
         begin
            pkt.cmd      = emesh_pkg::emesh_cmd_e'(f_cmd[0]);
            pkt.size     = emesh_pkg::emesh_size_e'(f_size[1:0]);
            pkt.ctrlmode = f_ctrl[4:0];
            pkt.dstaddr  = f_dst;
            pkt.srcaddr  = f_src;
            pkt.data     = f_data;
            acc = (f_acc == 1);
            if (f_acc == 2)
            begin
               make_random_packet(pkt);
               acc = (m_fcount < `EMESH_PROG_FULL);  // only while wait_out is low
            end
            wt = f_wait[0];
            if (f_wait == 2)
            begin
               r  = $random(seed);
               wt = r[0];
            end
            drive_cycle(acc, pkt, wt);
         end
      end
      $fclose(fd);

      // drain with downstream always ready
      cycles = 0;
      while (((model_q.size() != 0) || access_out) && (cycles < DRAIN_LIMIT))
      begin
         drive_cycle(1'b0, '0, 1'b0);
         cycles++;
      end
      if ((model_q.size() != 0) || access_out)
         abort_run("timeout: buffer did not drain within the cycle limit");
      else
      begin
         check_status("status", expected_status(0), status);
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
verilog/emesh_pkg.sv
verilog/memory_dp.sv
verilog/fifo_sync.sv
verilog/fifo_egress.sv
verilog/emesh_fifo.sv
tests/tb_clock.sv
tests/tb_emesh_fifo.sv

/* Bender.yml */
package:
  name: emesh_fifo

export_include_dirs:
  - include

sources:
  # design
  - include_dirs:
      - include
    files:
      - verilog/emesh_pkg.sv
      - verilog/memory_dp.sv
      - verilog/fifo_sync.sv
      - verilog/fifo_egress.sv
      - verilog/emesh_fifo.sv
  # testbench
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock.sv
      - tests/tb_emesh_fifo.sv

/* tests/emesh_fifo_stimulus.txt */
// acc cmd size ctrlmode dstaddr srcaddr data wait, hex, one cycle per line
// acc 2 sends a random packet while wait_out is low, wait 2 gives a random wait_in
0 0 0 00 00000000 00000000 00000000 0
1 1 0 01 80000000 00000010 000000a5 0
1 0 1 02 80000004 00000014 0000beef 0
1 1 2 03 80000008 00000018 cafef00d 0
1 0 3 04 8000000c 0000001c 12345678 0
1 1 3 1f fffffffc 7ffffff0 ffffffff 0
0 0 0 00 00000000 00000000 00000000 0
0 0 0 00 00000000 00000000 00000000 0
1 1 0 05 40000000 00001000 00000001 1
1 0 1 06 40000004 00001004 00000002 1
1 1 2 07 40000008 00001008 00000003 1
1 0 3 08 4000000c 0000100c 00000004 1
1 1 0 09 40000010 00001010 00000005 1
1 0 1 0a 40000014 00001014 00000006 1
1 1 2 0b 40000018 00001018 00000007 1
1 0 3 0c 4000001c 0000101c 00000008 1
1 1 1 0d 40000020 00001020 00000009 1
0 0 0 00 00000000 00000000 00000000 1
0 0 0 00 00000000 00000000 00000000 1
0 0 0 00 00000000 00000000 00000000 0
0 0 0 00 00000000 00000000 00000000 0
0 0 0 00 00000000 00000000 00000000 0
1 0 2 10 20000000 00002000 55aa55aa 0
0 0 0 00 00000000 00000000 00000000 1
2 0 0 00 00000000 00000000 00000000 2
2 0 0 00 00000000 00000000 00000000 2
2 0 0 00 00000000 00000000 00000000 2
2 0 0 00 00000000 00000000 00000000 2
2 0 0 00 00000000 00000000 00000000 2
2 0 0 00 00000000 00000000 00000000 2
